// File: rtl/game_params.svh
/*
 * Fixed sizes, start positions, step period and colours of the game.
 * Included by the RTL modules and by the testbench top.
 */
`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

`define SCREEN_W        160     // Frame buffer columns
`define SCREEN_H        120     // Frame buffer rows
`define PLAYER_W        3       // Player square side
`define ENEMY_W         7       // Enemy square side

`define PLAYER_START_X  78      // Player row is fixed at SCREEN_H - PLAYER_W
`define ENEMY_START_X   80
`define ENEMY_START_Y   60

`define STEP_CYCLES     20480   // Clocks between motion steps

`define PLAYER_COLOUR   7
`define ENEMY_COLOUR    4
`define BG_COLOUR       0

`endif

// File: rtl/game_pkg.sv
/*
 * Types shared by the game modules: screen coordinates, colours,
 * the pixel stream payload, button bundle and the state machine encodings.
 */
package game_pkg;

    typedef logic [7:0] coord_x_t;  // 0..159
    typedef logic [6:0] coord_y_t;  // 0..119
    typedef logic [2:0] colour_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } pos_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
        colour_t  colour;
    } pixel_t;

    // Active high, debounced outside
    typedef struct packed {
        logic go;
        logic left;
        logic right;
    } buttons_t;

    typedef enum logic [2:0] {
        LEVEL_SELECT = 3'd0,
        LOAD_LEVEL   = 3'd1,
        LEVEL_PAUSE  = 3'd2,
        PLAY_START   = 3'd3,
        PLAY         = 3'd4,
        PAUSING      = 3'd6,
        GAME_OVER    = 3'd5
    } game_phase_t;

    typedef enum logic [1:0] {IDLE, ERASE, DRAW_PLAYER, DRAW_ENEMY} render_state_t;

endpackage

// File: rtl/game_controller.sv
/*
 * Game phase FSM. Go presses and releases walk the phases, and a
 * player/enemy overlap during play ends the game.
 */
`timescale 1ns/1ps
`include "game_params.svh"

module game_controller import game_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  buttons_t    buttons,
    input  pos_t        player_pos,
    input  pos_t        enemy_pos,
    output game_phase_t phase
);

    game_phase_t phase_next;
    logic [8:0]  player_right;  // One bit wider than a column
    logic [8:0]  enemy_right;
    logic [7:0]  player_bottom;
    logic [7:0]  enemy_bottom;
    logic        overlap;

    // Last column and row covered by each square, inclusive
    assign player_right  = {1'b0, player_pos.x} + 9'(`PLAYER_W - 1);
    assign enemy_right   = {1'b0, enemy_pos.x} + 9'(`ENEMY_W - 1);
    assign player_bottom = {1'b0, player_pos.y} + 8'(`PLAYER_W - 1);
    assign enemy_bottom  = {1'b0, enemy_pos.y} + 8'(`ENEMY_W - 1);

    assign overlap = ({1'b0, player_pos.x} <= enemy_right)
                  && ({1'b0, enemy_pos.x} <= player_right)
                  && ({1'b0, player_pos.y} <= enemy_bottom)
                  && ({1'b0, enemy_pos.y} <= player_bottom);

    always_comb begin
        phase_next = phase;
        case (phase)
            LEVEL_SELECT: if (buttons.go) phase_next = LOAD_LEVEL;
            LOAD_LEVEL:   if (!buttons.go) phase_next = LEVEL_PAUSE;
            LEVEL_PAUSE:  if (buttons.go) phase_next = PLAY_START;
            PLAY_START:   if (!buttons.go) phase_next = PLAY;
            PLAY: begin
                if (buttons.go) begin
                    phase_next = PAUSING;       // Pause wins over a hit
                end else if (overlap) begin
                    phase_next = GAME_OVER;
                end
            end
            PAUSING:      if (!buttons.go) phase_next = LEVEL_PAUSE;
            GAME_OVER:    if (buttons.go) phase_next = LOAD_LEVEL;
            default:      phase_next = LEVEL_SELECT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            phase <= LEVEL_SELECT;
        end else begin
            phase <= phase_next;
        end
    end

endmodule

// File: rtl/player_mover.sv
/*
 * Player square motion along the bottom row. Steps once per step
 * period during play, following left/right and clamped at the edges.
 */
`timescale 1ns/1ps
`include "game_params.svh"

module player_mover import game_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  buttons_t    buttons,
    input  game_phase_t phase,
    output pos_t        player_pos,
    output logic        player_moved
);

    localparam int STEP_W = $clog2(`STEP_CYCLES);

    logic [STEP_W-1:0] step_cnt;
    logic              step;
    coord_x_t          player_x;

    // Counter restarts on every entry to play
    assign step = (phase == PLAY) && (step_cnt == STEP_W'(`STEP_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            step_cnt     <= '0;
            player_x     <= coord_x_t'(`PLAYER_START_X);
            player_moved <= 1'b0;
        end else begin
            player_moved <= 1'b0;

            if (phase != PLAY || step) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end

            if (phase == LOAD_LEVEL) begin
                player_x <= coord_x_t'(`PLAYER_START_X);
            end else if (step) begin
                if (buttons.left && player_x != '0) begin
                    player_x     <= player_x - 1'b1;
                    player_moved <= 1'b1;
                end else if (buttons.right
                             && player_x < coord_x_t'(`SCREEN_W - `PLAYER_W)) begin
                    player_x     <= player_x + 1'b1;
                    player_moved <= 1'b1;
                end
            end
        end
    end

    assign player_pos.x = player_x;
    assign player_pos.y = coord_y_t'(`SCREEN_H - `PLAYER_W);    // Bottom row

endmodule

// File: rtl/enemy_mover.sv
/*
 * Enemy square that bounces diagonally off the screen edges.
 * One step per step period during play, every step moves it.
 */
`timescale 1ns/1ps
`include "game_params.svh"

module enemy_mover import game_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  game_phase_t phase,
    output pos_t        enemy_pos,
    output logic        enemy_moved
);

    localparam int STEP_W = $clog2(`STEP_CYCLES);

    logic [STEP_W-1:0] step_cnt;
    logic              step;
    logic              go_left;     // Column direction
    logic              go_up;       // Row direction
    coord_x_t          next_x;
    coord_y_t          next_y;

    assign step = (phase == PLAY) && (step_cnt == STEP_W'(`STEP_CYCLES - 1));

    assign next_x = go_left ? enemy_pos.x - 1'b1 : enemy_pos.x + 1'b1;
    assign next_y = go_up ? enemy_pos.y - 1'b1 : enemy_pos.y + 1'b1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            step_cnt    <= '0;
            enemy_pos.x <= coord_x_t'(`ENEMY_START_X);
            enemy_pos.y <= coord_y_t'(`ENEMY_START_Y);
            go_left     <= 1'b0;    // Starts right and down
            go_up       <= 1'b0;
            enemy_moved <= 1'b0;
        end else begin
            enemy_moved <= 1'b0;

            if (phase != PLAY || step) begin
                step_cnt <= '0;
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end

            if (phase == LOAD_LEVEL) begin
                enemy_pos.x <= coord_x_t'(`ENEMY_START_X);
                enemy_pos.y <= coord_y_t'(`ENEMY_START_Y);
                go_left     <= 1'b0;
                go_up       <= 1'b0;
            end else if (step) begin
                enemy_pos.x <= next_x;
                enemy_pos.y <= next_y;
                enemy_moved <= 1'b1;
                // Turn around after landing on an edge
                if (next_x == '0) go_left <= 1'b0;
                if (next_x == coord_x_t'(`SCREEN_W - `ENEMY_W)) go_left <= 1'b1;
                if (next_y == '0) go_up <= 1'b0;
                if (next_y == coord_y_t'(`SCREEN_H - `ENEMY_W)) go_up <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/frame_renderer.sv
/*
 * Turns frame requests into a pixel stream: full screen clear, then the
 * player square, then the enemy square. Game over gives a clear-only frame.
 */
`timescale 1ns/1ps
`include "game_params.svh"

module frame_renderer import game_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  game_phase_t phase,
    input  pos_t        player_pos,
    input  pos_t        enemy_pos,
    input  logic        player_moved,
    input  logic        enemy_moved,
    output pixel_t      pixel,
    output logic        pixel_valid,
    input  logic        pixel_ready
);

    game_phase_t   prev_phase;
    logic          load_entry;
    logic          over_entry;
    logic          req_frame;   // Full frame pending
    logic          req_erase;   // Clear-only frame pending
    logic          start_full;
    logic          start_erase;
    logic          erase_only;
    render_state_t state;
    render_state_t state_after;
    pos_t          snap_player;
    pos_t          snap_enemy;
    coord_x_t      cnt_x;
    coord_y_t      cnt_y;
    coord_x_t      org_x;
    coord_y_t      org_y;
    coord_x_t      span_x;      // Last relative column of current area
    coord_y_t      span_y;
    colour_t       colour;
    logic          accept;

    assign load_entry = (phase == LOAD_LEVEL) && (prev_phase != LOAD_LEVEL);
    assign over_entry = (phase == GAME_OVER) && (prev_phase != GAME_OVER);

    assign start_full  = (state == IDLE) && req_frame;
    assign start_erase = (state == IDLE) && !req_frame && req_erase;

    // Requests arriving mid-frame wait here and merge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            prev_phase <= LEVEL_SELECT;
            req_frame  <= 1'b0;
            req_erase  <= 1'b0;
        end else begin
            prev_phase <= phase;

            if (player_moved || enemy_moved || load_entry) begin
                req_frame <= 1'b1;
            end else if (start_full) begin
                req_frame <= 1'b0;
            end

            if (over_entry) begin
                req_erase <= 1'b1;
            end else if (load_entry || start_erase) begin
                req_erase <= 1'b0;  // A level frame clears the screen anyway
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_full) begin
            snap_player <= player_pos;
            snap_enemy  <= enemy_pos;
        end
    end

    always_comb begin
        case (state)
            DRAW_PLAYER: begin
                org_x       = snap_player.x;
                org_y       = snap_player.y;
                span_x      = coord_x_t'(`PLAYER_W - 1);
                span_y      = coord_y_t'(`PLAYER_W - 1);
                colour      = colour_t'(`PLAYER_COLOUR);
                state_after = DRAW_ENEMY;
            end
            DRAW_ENEMY: begin
                org_x       = snap_enemy.x;
                org_y       = snap_enemy.y;
                span_x      = coord_x_t'(`ENEMY_W - 1);
                span_y      = coord_y_t'(`ENEMY_W - 1);
                colour      = colour_t'(`ENEMY_COLOUR);
                state_after = IDLE;
            end
            default: begin                      // ERASE, IDLE
                org_x       = '0;
                org_y       = '0;
                span_x      = coord_x_t'(`SCREEN_W - 1);
                span_y      = coord_y_t'(`SCREEN_H - 1);
                colour      = colour_t'(`BG_COLOUR);
                state_after = erase_only ? IDLE : DRAW_PLAYER;
            end
        endcase
    end

    assign pixel_valid  = (state != IDLE);
    assign accept       = pixel_valid && pixel_ready;
    assign pixel.x      = org_x + cnt_x;
    assign pixel.y      = org_y + cnt_y;
    assign pixel.colour = colour;

    // Raster walk, advances only on an accepted pixel
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= IDLE;
            cnt_x      <= '0;
            cnt_y      <= '0;
            erase_only <= 1'b0;
        end else if (state == IDLE) begin
            if (start_full || start_erase) begin
                state      <= ERASE;
                erase_only <= start_erase;
                cnt_x      <= '0;
                cnt_y      <= '0;
            end
        end else if (accept) begin
            if (cnt_x == span_x) begin
                cnt_x <= '0;
                if (cnt_y == span_y) begin
                    cnt_y <= '0;
                    state <= state_after;   // Area done
                end else begin
                    cnt_y <= cnt_y + 1'b1;
                end
            end else begin
                cnt_x <= cnt_x + 1'b1;
            end
        end
    end

endmodule

// File: rtl/arcade_top.sv
/*
 * Game core top. Controller, both movers and the renderer, producing
 * a valid/ready pixel stream for a 160x120 frame buffer writer.
 */
`timescale 1ns/1ps

module arcade_top import game_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  buttons_t    buttons,
    input  logic        pixel_ready,
    output pixel_t      pixel,
    output logic        pixel_valid,
    output game_phase_t phase
);

    pos_t player_pos;
    pos_t enemy_pos;
    logic player_moved;
    logic enemy_moved;

    game_controller u_controller (
        .clk        (clk),
        .resetn     (resetn),
        .buttons    (buttons),
        .player_pos (player_pos),
        .enemy_pos  (enemy_pos),
        .phase      (phase)
    );

    player_mover u_player (
        .clk          (clk),
        .resetn       (resetn),
        .buttons      (buttons),
        .phase        (phase),
        .player_pos   (player_pos),
        .player_moved (player_moved)
    );

    enemy_mover u_enemy (
        .clk         (clk),
        .resetn      (resetn),
        .phase       (phase),
        .enemy_pos   (enemy_pos),
        .enemy_moved (enemy_moved)
    );

    frame_renderer u_renderer (
        .clk          (clk),
        .resetn       (resetn),
        .phase        (phase),
        .player_pos   (player_pos),
        .enemy_pos    (enemy_pos),
        .player_moved (player_moved),
        .enemy_moved  (enemy_moved),
        .pixel        (pixel),
        .pixel_valid  (pixel_valid),
        .pixel_ready  (pixel_ready)
    );

endmodule

// File: testbench/tb_tasks.svh
/*
 * Directed tests, compare helper and reference model of the two movers.
 * Included inside the testbench top module.
 */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

int m_px;                       // Reference player column
int m_ex;
int m_ey;
bit m_left;                     // Enemy heading left
bit m_up;

task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
        $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
        error_count++;
    end
endtask

task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
        pass_count++;
        $display("Test %s: ok", name);
    end else begin
        fail_count++;
        $display("Test %s: FAILED", name);
    end
endtask

// Expected stream content from the frame layout rules
task automatic check_stream_pixel();
    int j;
    int ex;
    int ey;
    int ec;
    if (idx == FRAME_AREA) cur_player = pixel;
    if (idx == FRAME_AREA + `PLAYER_W * `PLAYER_W) cur_enemy = pixel;
    if (idx < FRAME_AREA) begin
        ex = idx % `SCREEN_W;
        ey = idx / `SCREEN_W;
        ec = `BG_COLOUR;
    end else if (idx < FRAME_AREA + `PLAYER_W * `PLAYER_W) begin
        j  = idx - FRAME_AREA;
        ex = cur_player.x + j % `PLAYER_W;
        ey = cur_player.y + j / `PLAYER_W;
        ec = `PLAYER_COLOUR;
    end else begin
        j  = idx - FRAME_AREA - `PLAYER_W * `PLAYER_W;
        ex = cur_enemy.x + j % `ENEMY_W;
        ey = cur_enemy.y + j / `ENEMY_W;
        ec = `ENEMY_COLOUR;
    end
    if (idx >= FULL_FRAME || pixel.x != ex || pixel.y != ey || pixel.colour != ec) begin
        seq_errors++;
    end
endtask

task automatic model_reset();
    m_px   = `PLAYER_START_X;
    m_ex   = `ENEMY_START_X;
    m_ey   = `ENEMY_START_Y;
    m_left = 1'b0;
    m_up   = 1'b0;
endtask

task automatic model_step(input bit left, input bit right);
    if (left && m_px > 0) m_px--;
    else if (right && m_px < `SCREEN_W - `PLAYER_W) m_px++;
    m_ex = m_left ? m_ex - 1 : m_ex + 1;
    m_ey = m_up ? m_ey - 1 : m_ey + 1;
    if (m_ex == 0) m_left = 1'b0;
    if (m_ex == `SCREEN_W - `ENEMY_W) m_left = 1'b1;
    if (m_ey == 0) m_up = 1'b0;
    if (m_ey == `SCREEN_H - `ENEMY_W) m_up = 1'b1;
endtask

function automatic bit squares_overlap(input int px, input int py, input int ex, input int ey);
    return (px <= ex + `ENEMY_W - 1) && (ex <= px + `PLAYER_W - 1)
        && (py <= ey + `ENEMY_W - 1) && (ey <= py + `PLAYER_W - 1);
endfunction

task automatic set_buttons(input logic go, input logic left, input logic right);
    @(posedge clk);
    buttons <= {go, left, right};
endtask

task automatic wait_phase(input game_phase_t target);
    int n;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (phase != target && n < 10);
    check_value("phase", target, phase);
endtask

task automatic wait_frame();
    int n;
    n = 0;
    while (frames_done == frames_taken && n < 100_000) begin
        @(negedge clk);
        n++;
    end
    if (frames_done == frames_taken) begin
        $display("No frame finished within %0d cycles at %0t ns", n, $time);
        error_count++;
    end
    frames_taken = frames_done;
endtask

// Compare one full frame against the model positions
task automatic check_full_frame();
    check_value("frame length", FULL_FRAME, last_count);
    check_value("player x", m_px, last_player.x);
    check_value("player y", `SCREEN_H - `PLAYER_W, last_player.y);
    check_value("enemy x", m_ex, last_enemy.x);
    check_value("enemy y", m_ey, last_enemy.y);
    check_value("pixel order errors", 0, seq_errors);
endtask

task automatic test_phase_walk();
    int errs;
    errs = error_count;
    @(negedge clk);
    check_value("phase", LEVEL_SELECT, phase);
    repeat (100) begin
        @(negedge clk);
        if (pixel_valid) check_value("pixel_valid", 0, pixel_valid);
    end
    set_buttons(1, 0, 0);
    wait_phase(LOAD_LEVEL);
    set_buttons(0, 0, 0);
    wait_phase(LEVEL_PAUSE);
    set_buttons(1, 0, 0);
    wait_phase(PLAY_START);
    set_buttons(0, 0, 0);
    wait_phase(PLAY);
    set_buttons(1, 0, 0);
    wait_phase(PAUSING);
    set_buttons(0, 0, 0);
    wait_phase(LEVEL_PAUSE);
    report_test("phase walk", errs);
endtask

task automatic test_level_frame();
    int errs;
    errs = error_count;
    wait_frame();
    check_full_frame();
    report_test("level frame", errs);
endtask

task automatic test_hit_game_over();
    int  errs;
    int  k;
    errs = error_count;
    set_buttons(1, 0, 1);
    wait_phase(PLAY_START);
    set_buttons(0, 0, 1);
    wait_phase(PLAY);
    k = 0;
    do begin
        model_step(0, 1);
        wait_frame();
        check_full_frame();
        k++;
    end while (!squares_overlap(m_px, `SCREEN_H - `PLAYER_W, m_ex, m_ey) && k < 80);
    if (!squares_overlap(last_player.x, last_player.y, last_enemy.x, last_enemy.y)) begin
        $display("Last drawn player and enemy do not overlap at %0t ns", $time);
        error_count++;
    end
    check_value("phase", GAME_OVER, phase);
    wait_frame();                       // Erase-only frame
    check_value("erase frame length", FRAME_AREA, last_count);
    check_value("pixel order errors", 0, seq_errors);
    random_ready = 1'b1;                // Next level frame runs with back-pressure
    set_buttons(1, 0, 0);
    wait_phase(LOAD_LEVEL);
    @(negedge clk);
    check_value("player x", `PLAYER_START_X, UUT.u_player.player_pos.x);
    check_value("enemy x", `ENEMY_START_X, UUT.u_enemy.enemy_pos.x);
    check_value("enemy y", `ENEMY_START_Y, UUT.u_enemy.enemy_pos.y);
    set_buttons(0, 0, 0);
    wait_phase(LEVEL_PAUSE);
    report_test("hit and game over", errs);
endtask

task automatic test_backpressure_frame();
    int errs;
    errs = error_count;
    model_reset();
    wait_frame();
    check_full_frame();
    check_value("stall changes", 0, stall_errors);
    random_ready = 1'b0;
    report_test("back-pressure frame", errs);
endtask

task automatic test_player_motion();
    int errs;
    int extra;
    errs  = error_count;
    extra = 0;
    set_buttons(1, 1, 0);
    wait_phase(PLAY_START);
    set_buttons(0, 1, 0);
    wait_phase(PLAY);
    // Left until the edge, then a few steps pushing against it
    while (extra < 3) begin
        if (m_px == 0) extra++;
        model_step(1, 0);
        wait_frame();
        check_full_frame();
    end
    set_buttons(0, 0, 1);
    extra = 0;
    // Same to the right edge at column 157
    while (extra < 3) begin
        if (m_px == `SCREEN_W - `PLAYER_W) extra++;
        model_step(0, 1);
        wait_frame();
        check_full_frame();
    end
    check_value("phase", PLAY, phase);
    set_buttons(0, 0, 0);
    report_test("player motion", errs);
endtask

`endif

// File: testbench/tb_arcade.sv
/*
 * Testbench for the arcade game core. Drives go/left/right and pixel_ready,
 * records every accepted pixel into frame records and runs directed tests.
 */
`timescale 1ns/1ps
`include "game_params.svh"

module tb_arcade import game_pkg::*; ();

    localparam int FRAME_AREA = `SCREEN_W * `SCREEN_H;
    localparam int FULL_FRAME = FRAME_AREA + `PLAYER_W * `PLAYER_W + `ENEMY_W * `ENEMY_W;
    // About 292 motion steps of 20480 cycles and four level frames, plus 10 percent
    localparam int TIMEOUT_CYCLES = 6_700_000;

    logic        clk;
    logic        resetn;
    buttons_t    buttons;
    logic        pixel_ready;
    pixel_t      pixel;
    logic        pixel_valid;
    game_phase_t phase;

    integer seed = 32'hd718_1dc3;
    logic   random_ready;
    int     cycles;
    int     error_count;
    int     pass_count;
    int     fail_count;

    // Frame record filled by the pixel monitor
    int     idx;
    logic   in_frame;
    pixel_t cur_player;
    pixel_t cur_enemy;
    int     frames_done;
    int     frames_taken;
    int     last_count;
    pixel_t last_player;
    pixel_t last_enemy;
    int     seq_errors;
    int     stall_errors;
    logic   held;
    pixel_t held_pixel;

    arcade_top UUT (
        .clk         (clk),
        .resetn      (resetn),
        .buttons     (buttons),
        .pixel_ready (pixel_ready),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .phase       (phase)
    );

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Ready held high unless back-pressure is switched on
    always @(posedge clk) begin
        if (random_ready) begin
            pixel_ready <= $random(seed) & 1;
        end else begin
            pixel_ready <= 1'b1;
        end
    end

    // Pixel monitor samples at the falling edge where everything is stable
    always @(negedge clk) begin
        if (!resetn) begin
            idx      = 0;
            in_frame = 1'b0;
            held     = 1'b0;
        end else begin
            if (held) begin
                if (!pixel_valid || pixel !== held_pixel) stall_errors++;
                held = 1'b0;
            end
            if (pixel_valid) begin
                in_frame = 1'b1;
                if (pixel_ready) begin
                    check_stream_pixel();
                    idx++;
                end else begin
                    held       = 1'b1;      // Must not change until accepted
                    held_pixel = pixel;
                end
            end else if (in_frame) begin
                frames_done++;
                last_count  = idx;
                last_player = cur_player;
                last_enemy  = cur_enemy;
                in_frame    = 1'b0;
                idx         = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        resetn       = 1'b0;
        buttons      = '0;
        pixel_ready  = 1'b1;
        random_ready = 1'b0;
        cycles       = 0;
        error_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        frames_done  = 0;
        frames_taken = 0;
        seq_errors   = 0;
        stall_errors = 0;
        model_reset();
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        test_phase_walk();
        test_level_frame();
        test_hit_game_over();
        test_backpressure_frame();
        test_player_motion();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+rtl
+incdir+testbench
rtl/game_pkg.sv
rtl/game_controller.sv
rtl/player_mover.sv
rtl/enemy_mover.sv
rtl/frame_renderer.sv
rtl/arcade_top.sv
testbench/tb_arcade.sv
